/* RetireTypes.sv */
/*
 * Retire types
 * Commit width, active list sizing, entry layout and the
 * register mapping report sent back to rename.
 */
`default_nettype none

package RetireTypes;

    localparam int COMMIT_WIDTH      = 4;   // Head lanes examined per cycle
    localparam int ACTIVE_LIST_DEPTH = 16;

    typedef logic [3:0]  ActiveListIndex;
    typedef logic [4:0]  ActiveListCount;   // 0 .. ACTIVE_LIST_DEPTH
    typedef logic [1:0]  LaneIndex;
    typedef logic [2:0]  LaneCount;         // 0 .. COMMIT_WIDTH
    typedef logic [31:0] PcWord;
    typedef logic [4:0]  LogRegNum;
    typedef logic [5:0]  PhyRegNum;

    // One micro-op as held in the active list
    typedef struct packed {
        PcWord    pc;
        logic     last;           // Final op of its instruction
        logic     isBranch;
        logic     isLoad;
        logic     isStore;
        logic     writeReg;       // Op has a destination register
        LogRegNum logDstRegNum;
        PhyRegNum phyDstRegNum;
    } ActiveListEntry;

    // Retired mapping per lane, consumed by the rename logic
    typedef struct packed {
        logic     valid;
        LogRegNum logDstRegNum;
        PhyRegNum phyDstRegNum;
    } RetiredMapping;

endpackage

`default_nettype wire

/* RecoveryTypes.sv */
/*
 * Recovery types
 * Execution states written back by completion, refetch kinds,
 * pipeline phase and the request passed to the recovery controller.
 */
`default_nettype none

package RecoveryTypes;

    localparam int RECOVERY_CYCLES = 2;     // Cycles spent in PHASE_RECOVER

    typedef logic [1:0] RecoveryCount;      // Holds 0 .. RECOVERY_CYCLES-1

    typedef enum logic [3:0] {
        NOT_FINISHED,
        SUCCESS,
        REFETCH_NEXT,
        REFETCH_THIS,
        TRAP_ECALL,
        TRAP_EBREAK,
        TRAP_MRET,
        FAULT_INSN_MISALIGNED,
        FAULT_LOAD_MISALIGNED,
        FAULT_LOAD_VIOLATION,
        FAULT_STORE_MISALIGNED,
        FAULT_STORE_VIOLATION,
        FAULT_INSN_ILLEGAL,
        FAULT_INSN_VIOLATION
    } ExecutionState;

    typedef enum logic [2:0] {
        THIS_PC,
        NEXT_PC,
        BRANCH_TARGET,
        STORE_NEXT_PC,
        NEXT_PC_TO_CSR_TARGET,
        THIS_PC_TO_CSR_TARGET
    } RefetchType;

    typedef enum logic {
        PHASE_COMMIT,
        PHASE_RECOVER
    } PipelinePhase;

    typedef struct packed {
        logic                valid;
        RefetchType          refetchType;
        ExecutionState       cause;
        RetireTypes::PcWord  pc;          // PC of the recovery lane
    } RecoveryRequest;

endpackage

`default_nettype wire

/* ActiveList.sv */
/*
 * Active list
 * Circular in-order buffer of dispatched micro-ops with completion
 * state writes, a multi-entry head read, pop and flush.
 */
`default_nettype none

module ActiveList
    import RetireTypes::*;
    import RecoveryTypes::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  logic           dispatchValid,
    input  ActiveListEntry dispatchEntry,
    output logic           dispatchReady,
    input  logic           completeValid,
    input  ActiveListIndex completeIndex,
    input  ExecutionState  completeState,
    input  LaneCount       popNum,
    output ActiveListEntry headEntry [COMMIT_WIDTH],
    output ExecutionState  headState [COMMIT_WIDTH],
    output ActiveListCount validEntryNum
);

    ActiveListEntry entries [ACTIVE_LIST_DEPTH];    // Payload storage
    ExecutionState  states [ACTIVE_LIST_DEPTH];

    ActiveListIndex headPtr;
    ActiveListIndex tailPtr;
    ActiveListCount count;
    logic           push;

    assign dispatchReady = (count != ActiveListCount'(ACTIVE_LIST_DEPTH));
    assign push          = dispatchValid && dispatchReady;
    assign validEntryNum = count;

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            headPtr <= headPtr + ActiveListIndex'(popNum);
            count   <= count + ActiveListCount'(push) - ActiveListCount'(popNum);
        end
    end

    // Entry and state writes
    always_ff @(posedge clk) begin
        if (completeValid && !flush) begin
            states[completeIndex] <= completeState;
        end
        if (push && !flush) begin
            entries[tailPtr] <= dispatchEntry;
            states[tailPtr]  <= NOT_FINISHED;    // Fresh op waits for completion
        end
    end

    // Head window, wraps with the 4-bit pointer
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            headEntry[i] = entries[headPtr + ActiveListIndex'(i)];
            headState[i] = states[headPtr + ActiveListIndex'(i)];
        end
    end

endmodule

`default_nettype wire

/* CommitDecider.sv */
/*
 * Commit decider
 * Picks the lanes to retire among the head entries, in whole
 * instructions, and the earliest recovery point with its refetch type.
 */
`default_nettype none

module CommitDecider
    import RetireTypes::*;
    import RecoveryTypes::*;
(
    input  logic                    startCommit,
    input  ActiveListCount          validEntryNum,
    input  ActiveListEntry          headEntry [COMMIT_WIDTH],
    input  ExecutionState           headState [COMMIT_WIDTH],
    input  logic                    unableToStartRecovery,
    output logic [COMMIT_WIDTH-1:0] commit,
    output logic                    toRecovery,
    output LaneIndex                recoveryLane,
    output RefetchType              refetchType,
    output ExecutionState           recoveryCause
);

    LaneIndex   headOfInsn [COMMIT_WIDTH];
    LaneIndex   tailOfInsn [COMMIT_WIDTH];
    logic       recovery [COMMIT_WIDTH];
    LaneIndex   recoveryPoint [COMMIT_WIDTH];
    RefetchType laneRefetch [COMMIT_WIDTH];

    LaneCount   finishedOpNum;
    LaneCount   finishedInsnRange;
    logic       recoveryTrigger;
    LaneCount   recoveryStart;

    // Instruction boundaries from the last flags
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            headOfInsn[i] = '0;
            for (int j = 0; j < i; j++) begin
                if (headEntry[j].last) headOfInsn[i] = LaneIndex'(j + 1);
            end
            tailOfInsn[i] = LaneIndex'(COMMIT_WIDTH - 1);
            for (int j = COMMIT_WIDTH - 1; j >= i; j--) begin
                if (headEntry[j].last) tailOfInsn[i] = LaneIndex'(j);    // Lowest last wins
            end
        end
    end

    // Finished run, then trimmed back to a whole instruction
    always_comb begin : finishedRange
        logic stop;
        stop = 1'b0;
        finishedOpNum = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (!stop && i < validEntryNum && headState[i] != NOT_FINISHED) begin
                finishedOpNum = LaneCount'(i + 1);
            end else begin
                stop = 1'b1;
            end
        end
        finishedInsnRange = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (i < finishedOpNum && headEntry[i].last) finishedInsnRange = LaneCount'(i + 1);
        end
    end

    // Per-lane recovery classification
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            recovery[i]      = 1'b1;
            recoveryPoint[i] = tailOfInsn[i];
            laneRefetch[i]   = THIS_PC;
            case (headState[i])
                REFETCH_NEXT: begin
                    laneRefetch[i] = headEntry[i].isBranch ? BRANCH_TARGET :
                                     headEntry[i].isStore  ? STORE_NEXT_PC : NEXT_PC;
                end
                REFETCH_THIS: recoveryPoint[i] = headOfInsn[i];
                TRAP_ECALL, TRAP_EBREAK, TRAP_MRET, FAULT_INSN_MISALIGNED: begin
                    laneRefetch[i] = NEXT_PC_TO_CSR_TARGET;
                end
                FAULT_LOAD_MISALIGNED, FAULT_LOAD_VIOLATION, FAULT_STORE_MISALIGNED,
                FAULT_STORE_VIOLATION, FAULT_INSN_ILLEGAL, FAULT_INSN_VIOLATION: begin
                    recoveryPoint[i] = headOfInsn[i];
                    laneRefetch[i]   = THIS_PC_TO_CSR_TARGET;
                end
                default: recovery[i] = 1'b0;    // Not finished or plain success
            endcase
        end
    end

    // Earliest recovery point, lowest lane on a tie
    always_comb begin
        recoveryTrigger = 1'b0;
        recoveryStart   = LaneCount'(COMMIT_WIDTH);
        recoveryLane    = '0;
        refetchType     = THIS_PC;
        recoveryCause   = SUCCESS;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (i < finishedInsnRange && recovery[i]
                && LaneCount'(recoveryPoint[i]) < recoveryStart) begin
                recoveryTrigger = 1'b1;
                recoveryStart   = LaneCount'(recoveryPoint[i]);
                recoveryLane    = LaneIndex'(i);
                refetchType     = laneRefetch[i];
                recoveryCause   = headState[i];
            end
        end
    end

    assign toRecovery = startCommit && recoveryTrigger && !unableToStartRecovery;

    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (!startCommit) begin
                commit[i] = 1'b0;
            end else if (!recoveryTrigger) begin
                commit[i] = (i < finishedInsnRange);
            end else if (i < recoveryStart) begin
                commit[i] = 1'b1;
            end else if (i == recoveryStart) begin
                // Refetch-this and most faults re-execute the lane itself
                commit[i] = !(headState[i] inside {REFETCH_THIS, FAULT_LOAD_MISALIGNED,
                              FAULT_LOAD_VIOLATION, FAULT_STORE_MISALIGNED,
                              FAULT_STORE_VIOLATION, FAULT_INSN_ILLEGAL,
                              FAULT_INSN_VIOLATION} || unableToStartRecovery);
            end else begin
                commit[i] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* RetireStage.sv */
/*
 * Retire stage
 * Applies the commit decision: pop count, retired register mappings,
 * load and store counts, last committed PC and the recovery request.
 */
`default_nettype none

module RetireStage
    import RetireTypes::*;
    import RecoveryTypes::*;
(
    input  logic           clk,
    input  logic           rst,
    input  PipelinePhase   phase,
    input  ActiveListEntry headEntry [COMMIT_WIDTH],
    input  ExecutionState  headState [COMMIT_WIDTH],
    input  ActiveListCount validEntryNum,
    input  logic           unableToStartRecovery,
    output LaneCount       popNum,
    output RetiredMapping  retiredMap [COMMIT_WIDTH],
    output LaneCount       commitLoadNum,
    output LaneCount       commitStoreNum,
    output PcWord          lastCommittedPc,
    output RecoveryRequest recoveryOut
);

    logic [COMMIT_WIDTH-1:0] commit;
    logic                    toRecovery;
    LaneIndex                recoveryLane;
    RefetchType              refetchType;
    ExecutionState           recoveryCause;
    PcWord                   youngestPc;

    CommitDecider CommitDecider_inst (
        .startCommit          (phase == PHASE_COMMIT),
        .validEntryNum        (validEntryNum),
        .headEntry            (headEntry),
        .headState            (headState),
        .unableToStartRecovery(unableToStartRecovery),
        .commit               (commit),
        .toRecovery           (toRecovery),
        .recoveryLane         (recoveryLane),
        .refetchType          (refetchType),
        .recoveryCause        (recoveryCause)
    );

    // Counts and mappings of the committed lanes
    always_comb begin
        popNum         = '0;
        commitLoadNum  = '0;
        commitStoreNum = '0;
        youngestPc     = lastCommittedPc;    // Hold when nothing retires
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            retiredMap[i] = '0;
            if (commit[i]) begin
                popNum = popNum + LaneCount'(1);
                if (headEntry[i].isLoad) commitLoadNum = commitLoadNum + LaneCount'(1);
                if (headEntry[i].isStore) commitStoreNum = commitStoreNum + LaneCount'(1);
                retiredMap[i].valid        = headEntry[i].writeReg;
                retiredMap[i].logDstRegNum = headEntry[i].logDstRegNum;
                retiredMap[i].phyDstRegNum = headEntry[i].phyDstRegNum;
                youngestPc = headEntry[i].pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lastCommittedPc <= '0;
        end else begin
            lastCommittedPc <= youngestPc;
        end
    end

    // Request toward the recovery controller
    always_comb begin
        recoveryOut.valid       = toRecovery;
        recoveryOut.refetchType = refetchType;
        recoveryOut.cause       = recoveryCause;
        recoveryOut.pc          = headEntry[recoveryLane].pc;
    end

endmodule

`default_nettype wire

/* RecoveryController.sv */
/*
 * Recovery controller
 * Two-phase FSM: on a request it enters recovery for a fixed number
 * of cycles, flushing the active list and issuing one refetch.
 */
`default_nettype none

module RecoveryController
    import RetireTypes::*;
    import RecoveryTypes::*;
(
    input  logic           clk,
    input  logic           rst,
    input  RecoveryRequest recoveryIn,
    output PipelinePhase   phase,
    output logic           flush,
    output logic           refetchValid,
    output RefetchType     refetchType,
    output PcWord          refetchPc
);

    RecoveryCount cyclesLeft;
    logic         entryPulse;    // High in the first recover cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= PHASE_COMMIT;
            cyclesLeft <= '0;
            entryPulse <= 1'b0;
        end else begin
            entryPulse <= 1'b0;
            case (phase)
                PHASE_COMMIT: begin
                    if (recoveryIn.valid) begin
                        phase      <= PHASE_RECOVER;
                        cyclesLeft <= RecoveryCount'(RECOVERY_CYCLES - 1);
                        entryPulse <= 1'b1;
                    end
                end
                default: begin
                    if (cyclesLeft == '0) phase <= PHASE_COMMIT;
                    else cyclesLeft <= cyclesLeft - 1'b1;
                end
            endcase
        end
    end

    // Refetch target, latched with the request
    always_ff @(posedge clk) begin
        if (phase == PHASE_COMMIT && recoveryIn.valid) begin
            refetchType <= recoveryIn.refetchType;
            refetchPc   <= recoveryIn.pc;
        end
    end

    assign flush        = entryPulse;
    assign refetchValid = entryPulse;

endmodule

`default_nettype wire

/* RetireUnit.sv */
/*
 * Retire unit top
 * Active list, retire stage and recovery controller.
 */
`default_nettype none

module RetireUnit
    import RetireTypes::*;
    import RecoveryTypes::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           dispatchValid,
    input  ActiveListEntry dispatchEntry,
    output logic           dispatchReady,
    input  logic           completeValid,
    input  ActiveListIndex completeIndex,
    input  ExecutionState  completeState,
    input  logic           unableToStartRecovery,
    output ActiveListCount validEntryNum,
    output LaneCount       popNum,
    output RetiredMapping  retiredMap [COMMIT_WIDTH],
    output LaneCount       commitLoadNum,
    output LaneCount       commitStoreNum,
    output PcWord          lastCommittedPc,
    output PipelinePhase   phase,
    output logic           flush,
    output logic           refetchValid,
    output RefetchType     refetchType,
    output PcWord          refetchPc
);

    ActiveListEntry headEntry [COMMIT_WIDTH];
    ExecutionState  headState [COMMIT_WIDTH];
    RecoveryRequest recoveryRequest;
    logic           dispatchAccept;

    assign dispatchAccept = dispatchValid && (phase == PHASE_COMMIT);   // No pushes in recovery

    ActiveList ActiveList_inst (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .dispatchValid(dispatchAccept),
        .dispatchEntry(dispatchEntry),
        .dispatchReady(dispatchReady),
        .completeValid(completeValid),
        .completeIndex(completeIndex),
        .completeState(completeState),
        .popNum       (popNum),
        .headEntry    (headEntry),
        .headState    (headState),
        .validEntryNum(validEntryNum)
    );

    RetireStage RetireStage_inst (
        .clk                  (clk),
        .rst                  (rst),
        .phase                (phase),
        .headEntry            (headEntry),
        .headState            (headState),
        .validEntryNum        (validEntryNum),
        .unableToStartRecovery(unableToStartRecovery),
        .popNum               (popNum),
        .retiredMap           (retiredMap),
        .commitLoadNum        (commitLoadNum),
        .commitStoreNum       (commitStoreNum),
        .lastCommittedPc      (lastCommittedPc),
        .recoveryOut          (recoveryRequest)
    );

    RecoveryController RecoveryController_inst (
        .clk         (clk),
        .rst         (rst),
        .recoveryIn  (recoveryRequest),
        .phase       (phase),
        .flush       (flush),
        .refetchValid(refetchValid),
        .refetchType (refetchType),
        .refetchPc   (refetchPc)
    );

endmodule

`default_nettype wire

/* RetireChecker.sv */
/*
 * Retire checker
 * Keeps a shadow active list from observed pushes, completions and
 * flushes, predicts each commit decision and compares the DUT outputs.
 */
`default_nettype none

module RetireChecker
    import RetireTypes::*;
    import RecoveryTypes::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           dispatchValid,
    input  ActiveListEntry dispatchEntry,
    input  logic           dispatchReady,
    input  logic           completeValid,
    input  ActiveListIndex completeIndex,
    input  ExecutionState  completeState,
    input  logic           unableToStartRecovery,
    input  ActiveListCount validEntryNum,
    input  LaneCount       popNum,
    input  RetiredMapping  retiredMap [COMMIT_WIDTH],
    input  LaneCount       commitLoadNum,
    input  LaneCount       commitStoreNum,
    input  PcWord          lastCommittedPc,
    input  PipelinePhase   phase,
    input  logic           flush,
    input  logic           refetchValid,
    input  RefetchType     refetchType,
    input  PcWord          refetchPc,
    output int             checkCount,
    output int             errorCount,
    output int             refetchCount
);

    typedef struct packed {
        logic [COMMIT_WIDTH-1:0] mask;      // Lanes expected to retire
        logic                    recover;   // Request goes out this cycle
        RefetchType              kind;
        PcWord                   pc;
    } Decision;

    ActiveListEntry shadowEntry [ACTIVE_LIST_DEPTH];
    ExecutionState  shadowState [ACTIVE_LIST_DEPTH];
    int             shadowHead;
    int             shadowTail;
    int             shadowCount;
    int             recoverLeft;    // Recover cycles still ahead
    RefetchType     expType;
    PcWord          expPc;
    PcWord          expLastPc;

    // Refetch-this and most faults restart at the head of their instruction
    function automatic logic restartsAtHead(input ExecutionState s);
        return s inside {REFETCH_THIS, FAULT_LOAD_MISALIGNED, FAULT_LOAD_VIOLATION,
                         FAULT_STORE_MISALIGNED, FAULT_STORE_VIOLATION,
                         FAULT_INSN_ILLEGAL, FAULT_INSN_VIOLATION};
    endfunction

    function automatic Decision referenceDecision(input logic canCommit, input logic blocked);
        Decision        d;
        ActiveListEntry e [COMMIT_WIDTH];
        ExecutionState  s [COMMIT_WIDTH];
        logic           running;
        int             avail;
        int             wholeEnd;
        int             insnHead;
        int             insnTail;
        int             point;
        int             bestPoint;
        int             bestLane;
        d     = '0;
        avail = (shadowCount < COMMIT_WIDTH) ? shadowCount : COMMIT_WIDTH;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            e[i] = shadowEntry[(shadowHead + i) % ACTIVE_LIST_DEPTH];
            s[i] = shadowState[(shadowHead + i) % ACTIVE_LIST_DEPTH];
        end
        // Only whole finished instructions count
        running  = 1'b1;
        wholeEnd = 0;
        for (int i = 0; i < avail; i++) begin
            if (s[i] == NOT_FINISHED) running = 1'b0;
            if (running && e[i].last) wholeEnd = i + 1;
        end
        bestPoint = COMMIT_WIDTH;
        bestLane  = -1;
        for (int i = 0; i < wholeEnd; i++) begin
            insnHead = i;
            while (insnHead > 0 && !e[insnHead - 1].last) insnHead--;
            insnTail = i;
            while (insnTail < COMMIT_WIDTH - 1 && !e[insnTail].last) insnTail++;
            point = restartsAtHead(s[i]) ? insnHead : insnTail;
            if (s[i] != SUCCESS && point < bestPoint) begin    // Strict, so lowest lane on a tie
                bestPoint = point;
                bestLane  = i;
            end
        end
        if (bestLane >= 0) begin
            d.pc = e[bestLane].pc;
            case (s[bestLane])
                REFETCH_NEXT: d.kind = e[bestLane].isBranch ? BRANCH_TARGET :
                                       (e[bestLane].isStore ? STORE_NEXT_PC : NEXT_PC);
                REFETCH_THIS: d.kind = THIS_PC;
                default: d.kind = restartsAtHead(s[bestLane]) ? THIS_PC_TO_CSR_TARGET
                                                               : NEXT_PC_TO_CSR_TARGET;
            endcase
        end
        d.recover = canCommit && bestLane >= 0 && !blocked;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (!canCommit) d.mask[i] = 1'b0;
            else if (bestLane < 0) d.mask[i] = (i < wholeEnd);
            else if (i == bestPoint) d.mask[i] = !(restartsAtHead(s[i]) || blocked);
            else d.mask[i] = (i < bestPoint);
        end
        return d;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expected, got);
        end
    endtask

    always @(posedge clk) begin : compareCycle
        Decision        dec;
        ActiveListEntry lane;
        RetiredMapping  expMap;
        logic           pulse;
        int             pops;
        int             loads;
        int             stores;
        if (rst) begin
            shadowHead   = 0;
            shadowTail   = 0;
            shadowCount  = 0;
            recoverLeft  = 0;
            expLastPc    = '0;
            checkCount   = 0;
            errorCount   = 0;
            refetchCount = 0;
        end else begin
            pulse  = (recoverLeft == RECOVERY_CYCLES);    // First recover cycle
            dec    = referenceDecision(recoverLeft == 0, unableToStartRecovery);
            pops   = 0;
            loads  = 0;
            stores = 0;
            checkValue("dispatchReady", dispatchReady, shadowCount != ACTIVE_LIST_DEPTH);
            checkValue("validEntryNum", validEntryNum, shadowCount);
            checkValue("phase", phase, recoverLeft != 0);
            checkValue("flush", flush, pulse);
            checkValue("refetchValid", refetchValid, pulse);
            if (pulse) begin
                refetchCount++;
                checkValue("refetchType", refetchType, expType);
                checkValue("refetchPc", refetchPc, expPc);
            end
            checkValue("lastCommittedPc", lastCommittedPc, expLastPc);
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                lane   = shadowEntry[(shadowHead + i) % ACTIVE_LIST_DEPTH];
                expMap = '0;
                if (dec.mask[i]) begin
                    pops++;
                    loads     += lane.isLoad;
                    stores    += lane.isStore;
                    expLastPc  = lane.pc;    // Youngest committed lane wins
                    expMap     = '{valid: lane.writeReg, logDstRegNum: lane.logDstRegNum,
                                   phyDstRegNum: lane.phyDstRegNum};
                end
                checkValue($sformatf("retiredMap[%0d]", i), retiredMap[i], expMap);
            end
            checkValue("popNum", popNum, pops);
            checkValue("commitLoadNum", commitLoadNum, loads);
            checkValue("commitStoreNum", commitStoreNum, stores);

            // Advance the shadow list
            if (pulse) begin
                shadowHead  = 0;
                shadowTail  = 0;
                shadowCount = 0;
            end else begin
                if (completeValid) shadowState[completeIndex] = completeState;
                if (dispatchValid && recoverLeft == 0 && shadowCount < ACTIVE_LIST_DEPTH) begin
                    shadowEntry[shadowTail] = dispatchEntry;
                    shadowState[shadowTail] = NOT_FINISHED;
                    shadowTail  = (shadowTail + 1) % ACTIVE_LIST_DEPTH;
                    shadowCount++;
                end
                shadowHead  = (shadowHead + pops) % ACTIVE_LIST_DEPTH;
                shadowCount = shadowCount - pops;
            end
            if (recoverLeft != 0) begin
                recoverLeft--;
            end else if (dec.recover) begin
                recoverLeft = RECOVERY_CYCLES;
                expType     = dec.kind;
                expPc       = dec.pc;
            end
        end
    end

endmodule

`default_nettype wire

/* RetireUnitTb.sv */
/*
 * Retire unit testbench
 * Random dispatch, out-of-order completion and recovery stalls
 * driven from an LCG, with a fill phase that reaches a full list.
 */
`default_nettype none

module RetireUnitTb
    import RetireTypes::*;
    import RecoveryTypes::*;
();

    localparam int TOTAL_OPS     = 400;
    localparam int WATCHDOG_TIME = TOTAL_OPS * 40 + 2000;

    logic           clk;
    logic           rst;
    logic           dispatchValid;
    ActiveListEntry dispatchEntry;
    logic           dispatchReady;
    logic           completeValid;
    ActiveListIndex completeIndex;
    ExecutionState  completeState;
    logic           unableToStartRecovery;
    ActiveListCount validEntryNum;
    LaneCount       popNum;
    RetiredMapping  retiredMap [COMMIT_WIDTH];
    LaneCount       commitLoadNum;
    LaneCount       commitStoreNum;
    PcWord          lastCommittedPc;
    PipelinePhase   phase;
    logic           flush;
    logic           refetchValid;
    RefetchType     refetchType;
    PcWord          refetchPc;
    int             checkCount;
    int             errorCount;
    int             refetchCount;

    logic [31:0]    lcgState;
    int             opsDispatched;
    int             insnOpsLeft;    // Ops still to send for the current instruction
    int             unableLeft;
    PcWord          nextPc;
    ActiveListIndex tbTail;
    ActiveListIndex outstanding [$];    // Pushed and not yet completed

    RetireUnit RetireUnit_inst (.*);

    RetireChecker RetireChecker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int nextRandom(input int range);
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return int'(lcgState[31:16]) % range;
    endfunction

    // Weighted toward SUCCESS with every recovery kind in the mix
    function automatic ExecutionState pickState();
        int r;
        r = nextRandom(32);
        if (r < 24) return SUCCESS;
        case (r)
            24: return REFETCH_NEXT;
            25: return REFETCH_THIS;
            26: return TRAP_ECALL;
            27: return TRAP_EBREAK;
            28: return TRAP_MRET;
            29: return FAULT_INSN_MISALIGNED;
            default: return ExecutionState'(4'(8 + nextRandom(6)));    // Remaining faults
        endcase
    endfunction

    function automatic ActiveListEntry makeEntry();
        ActiveListEntry e;
        int kind;
        kind           = nextRandom(4);
        e.pc           = nextPc;
        e.last         = (insnOpsLeft == 1);
        e.isBranch     = e.last && nextRandom(4) == 0;
        e.isLoad       = (kind == 1);
        e.isStore      = (kind == 2);
        e.writeReg     = (nextRandom(4) != 0);
        e.logDstRegNum = LogRegNum'(nextRandom(32));
        e.phyDstRegNum = PhyRegNum'(nextRandom(64));
        return e;
    endfunction

    task automatic driveCycle(input logic allowDispatch, input logic allowComplete);
        int pick;
        @(negedge clk);
        completeValid = 1'b0;
        if (allowComplete && outstanding.size() > 0 && nextRandom(8) < 5) begin
            pick          = nextRandom(outstanding.size());
            completeValid = 1'b1;
            completeIndex = outstanding[pick];
            completeState = pickState();
            outstanding.delete(pick);
        end
        dispatchValid = 1'b0;
        if (allowDispatch && nextRandom(4) != 0) begin
            if (insnOpsLeft == 0) insnOpsLeft = 1 + nextRandom(3);
            dispatchEntry = makeEntry();
            dispatchValid = 1'b1;
            if (dispatchReady && phase == PHASE_COMMIT) begin    // Accepted at the next edge
                outstanding.push_back(tbTail);
                tbTail = tbTail + 1'b1;
                opsDispatched++;
                insnOpsLeft--;
                nextPc += 4;
            end
        end
        if (unableLeft > 0) unableLeft--;
        else if (nextRandom(16) == 0) unableLeft = 1 + nextRandom(4);
        unableToStartRecovery = (unableLeft > 0);
        if (flush) begin    // List is emptied at the coming edge
            outstanding.delete();
            tbTail      = '0;
            insnOpsLeft = 0;
        end
    endtask

    initial begin
        rst                   = 1'b1;
        dispatchValid         = 1'b0;
        dispatchEntry         = '0;
        completeValid         = 1'b0;
        completeIndex         = '0;
        completeState         = NOT_FINISHED;
        unableToStartRecovery = 1'b0;
        lcgState              = 32'h1c22;
        opsDispatched         = 0;
        insnOpsLeft           = 0;
        unableLeft            = 0;
        nextPc                = 32'h0000_1000;
        tbTail                = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Fill the list with completions held back, then push against it while full
        while (dispatchReady) driveCycle(1'b1, 1'b0);
        repeat (3) driveCycle(1'b1, 1'b0);

        while (opsDispatched < TOTAL_OPS || insnOpsLeft != 0) driveCycle(1'b1, 1'b1);
        // Drain until every op has retired or been flushed
        while (!(outstanding.size() == 0 && validEntryNum == 0 && phase == PHASE_COMMIT)) begin
            driveCycle(1'b0, 1'b1);
        end
        repeat (3) driveCycle(1'b0, 1'b1);

        $display("Checks %0d, mismatches %0d, refetches %0d, ops dispatched %0d",
                 checkCount, errorCount, refetchCount, opsDispatched);
        if (errorCount == 0 && checkCount > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the retire unit did not drain within %0d time units", WATCHDOG_TIME);
        $display("Checks %0d, mismatches %0d, refetches %0d, ops dispatched %0d",
                 checkCount, errorCount, refetchCount, opsDispatched);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* retireUnit.f */
RetireTypes.sv
RecoveryTypes.sv
ActiveList.sv
CommitDecider.sv
RetireStage.sv
RecoveryController.sv
RetireUnit.sv
RetireChecker.sv
RetireUnitTb.sv

/* Bender.yml */
package:
  name: retireUnit

sources:
  - RetireTypes.sv
  - RecoveryTypes.sv
  - ActiveList.sv
  - CommitDecider.sv
  - RetireStage.sv
  - RecoveryController.sv
  - RetireUnit.sv
  - target: test
    files:
      - RetireChecker.sv
      - RetireUnitTb.sv
